/* rtl/sf_pkg.sv */
package sf_pkg;

  localparam int SF_W            = 4;   // widest scalefactor field
  localparam int NUM_LONG_BANDS  = 21;
  localparam int NUM_SHORT_BANDS = 12;
  localparam int NUM_WINDOWS     = 3;

  // one decoded scalefactor
  typedef logic [SF_W-1:0] sf_value_t;

  // field width in bits, 0 to 4
  typedef logic [2:0] slen_t;

  typedef struct packed {
    logic [3:0] scalefac_compress;
    logic       window_switching_flag;
    logic [1:0] block_type;
    logic [3:0] scfsi;               // bit n covers long region n
  } side_info_t;

  // where a finished field lands in the output arrays
  typedef struct packed {
    logic       is_short;
    logic [4:0] band;
    logic [1:0] window;              // only meaningful for short blocks
  } field_dest_t;

  typedef sf_value_t [NUM_LONG_BANDS-1:0] scalefac_l_t;

  // indexed [band][window]
  typedef sf_value_t [NUM_SHORT_BANDS-1:0][NUM_WINDOWS-1:0] scalefac_s_t;

endpackage

/* rtl/sf_field_seq.sv */
`timescale 1ns/1ps

module sf_field_seq #(
  parameter int GR = 0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                si_valid,
  input  sf_pkg::side_info_t  side_info,
  input  logic                bit_valid,
  input  logic                field_done,
  output logic                start,
  output sf_pkg::slen_t       field_width,
  output sf_pkg::field_dest_t field_dest,
  output logic                done
);
  import sf_pkg::*;

  typedef enum logic [1:0] {idle, run, finish} seq_state_t;

  seq_state_t state;
  side_info_t si_q;
  side_info_t si_cur;
  slen_t      slen1;
  slen_t      slen2;
  logic       is_short;
  slen_t      reg_width [4];
  logic [3:0] reg_live;
  logic       first_found;
  logic [1:0] first_region;
  logic       later_found;
  logic [1:0] later_region;
  logic [1:0] region_q;
  logic [4:0] band_q;
  logic [1:0] win_q;
  logic [1:0] cur_region;
  logic [4:0] cur_band;
  logic [1:0] cur_win;
  logic       cur_active;
  logic [1:0] nxt_region;
  logic [4:0] nxt_band;
  logic [1:0] nxt_win;
  logic       nxt_active;
  logic       step;

  function automatic logic [4:0] first_band(input logic short_blk, input logic [1:0] r);
    if (short_blk)
      return (r == 2'd0) ? 5'd0 : 5'd6;
    case (r)
      2'd0:    return 5'd0;
      2'd1:    return 5'd6;
      2'd2:    return 5'd11;
      default: return 5'd16;
    endcase
  endfunction

  function automatic logic [4:0] last_band(input logic short_blk, input logic [1:0] r);
    if (short_blk)
      return (r == 2'd0) ? 5'd5 : 5'(NUM_SHORT_BANDS - 1);
    case (r)
      2'd0:    return 5'd5;
      2'd1:    return 5'd10;
      2'd2:    return 5'd15;
      default: return 5'(NUM_LONG_BANDS - 1);
    endcase
  endfunction

  // the strobe cycle already works on the incoming side info
  assign si_cur   = si_valid ? side_info : si_q;
  assign is_short = si_cur.window_switching_flag && (si_cur.block_type == 2'd2);

  always_comb begin
    case (si_cur.scalefac_compress)
      4'd0:    {slen1, slen2} = {3'd0, 3'd0};
      4'd1:    {slen1, slen2} = {3'd0, 3'd1};
      4'd2:    {slen1, slen2} = {3'd0, 3'd2};
      4'd3:    {slen1, slen2} = {3'd0, 3'd3};
      4'd4:    {slen1, slen2} = {3'd3, 3'd0};
      4'd5:    {slen1, slen2} = {3'd1, 3'd1};
      4'd6:    {slen1, slen2} = {3'd1, 3'd2};
      4'd7:    {slen1, slen2} = {3'd1, 3'd3};
      4'd8:    {slen1, slen2} = {3'd2, 3'd1};
      4'd9:    {slen1, slen2} = {3'd2, 3'd2};
      4'd10:   {slen1, slen2} = {3'd2, 3'd3};
      4'd11:   {slen1, slen2} = {3'd3, 3'd1};
      4'd12:   {slen1, slen2} = {3'd3, 3'd2};
      4'd13:   {slen1, slen2} = {3'd3, 3'd3};
      4'd14:   {slen1, slen2} = {3'd4, 3'd2};
      default: {slen1, slen2} = {3'd4, 3'd3};
    endcase
  end

  // short blocks use only regions 0 and 1
  always_comb begin
    for (int r = 0; r < 4; r++) begin
      if (is_short)
        reg_width[r] = (r == 0) ? slen1 : ((r == 1) ? slen2 : 3'd0);
      else
        reg_width[r] = (r < 2) ? slen1 : slen2;
      reg_live[r] = (reg_width[r] != 3'd0) && !((GR != 0) && !is_short && si_cur.scfsi[r]);
    end
  end

  always_comb begin
    first_found  = 1'b0;
    first_region = 2'd0;
    for (int r = 3; r >= 0; r--) begin
      if (reg_live[r]) begin
        first_found  = 1'b1;
        first_region = 2'(r);
      end
    end
  end

  always_comb begin
    if (si_valid) begin
      cur_region = first_region;
      cur_band   = first_band(is_short, first_region);
      cur_win    = 2'd0;
      cur_active = first_found;
    end else begin
      cur_region = region_q;
      cur_band   = band_q;
      cur_win    = win_q;
      cur_active = (state == run);
    end
  end

  always_comb begin
    later_found  = 1'b0;
    later_region = 2'd0;
    for (int r = 3; r >= 0; r--) begin
      if (reg_live[r] && (r > int'(cur_region))) begin
        later_found  = 1'b1;
        later_region = 2'(r);
      end
    end
  end

  assign step = field_done && bit_valid && cur_active;  // a field only ends on an accepted bit

  always_comb begin
    nxt_region = cur_region;
    nxt_band   = cur_band;
    nxt_win    = cur_win;
    nxt_active = cur_active;
    if (step) begin
      if (is_short && (cur_win != 2'(NUM_WINDOWS - 1))) begin
        nxt_win = cur_win + 2'd1;  // window runs fastest
      end else if (cur_band != last_band(is_short, cur_region)) begin
        nxt_band = cur_band + 5'd1;
        nxt_win  = 2'd0;
      end else if (later_found) begin
        nxt_region = later_region;
        nxt_band   = first_band(is_short, later_region);
        nxt_win    = 2'd0;
      end else begin
        nxt_active = 1'b0;         // passed the last field
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= idle;
      si_q     <= '0;
      region_q <= 2'd0;
      band_q   <= 5'd0;
      win_q    <= 2'd0;
    end else if (si_valid || (state == run)) begin
      if (si_valid)
        si_q <= side_info;
      region_q <= nxt_region;
      band_q   <= nxt_band;
      win_q    <= nxt_win;
      state    <= nxt_active ? run : finish;
    end else if (state == finish) begin
      state <= idle;
    end
  end

  assign start       = si_valid;
  assign field_width = cur_active ? reg_width[cur_region] : 3'd0;  // zero width drops stray bits
  assign done        = (state == finish);

  always_comb begin
    field_dest.is_short = is_short;
    field_dest.band     = cur_band;
    field_dest.window   = cur_win;
  end

endmodule

/* rtl/sf_bit_collector.sv */
`timescale 1ns/1ps

module sf_bit_collector (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic              bit_valid,
  input  logic              bit_data,
  input  sf_pkg::slen_t     field_width,
  output sf_pkg::sf_value_t field_value,
  output logic              field_done
);
  import sf_pkg::*;

  sf_value_t shift_q;
  slen_t     count_q;
  sf_value_t shift_eff;
  slen_t     count_eff;
  sf_value_t shift_nxt;
  sf_value_t width_mask;
  logic      take_bit;

  // a new granule throws away any partial field
  always_comb begin
    shift_eff = start ? '0 : shift_q;
    count_eff = start ? '0 : count_q;
    take_bit  = bit_valid && (field_width != '0);
    shift_nxt = {shift_eff[SF_W-2:0], bit_data};  // first bit ends up as the field msb
  end

  always_comb begin
    for (int i = 0; i < SF_W; i++) begin
      width_mask[i] = (i < int'(field_width));
    end
  end

  assign field_done  = take_bit && (slen_t'(count_eff + 3'd1) == field_width);
  assign field_value = shift_nxt & width_mask;

  always_ff @(posedge clk) begin
    if (rst) begin
      shift_q <= '0;
      count_q <= '0;
    end else if (field_done || (start && !take_bit)) begin
      shift_q <= '0;
      count_q <= '0;
    end else if (take_bit) begin
      shift_q <= shift_nxt;
      count_q <= count_eff + 3'd1;
    end
  end

endmodule

/* rtl/sf_store.sv */
`timescale 1ns/1ps

module sf_store (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic                field_done,
  input  sf_pkg::field_dest_t field_dest,
  input  sf_pkg::sf_value_t   field_value,
  output sf_pkg::scalefac_l_t scalefac_l,
  output sf_pkg::scalefac_s_t scalefac_s
);
  import sf_pkg::*;

  logic long_hit;
  logic short_hit;

  // out of range destinations are dropped
  assign long_hit  = field_done && !field_dest.is_short &&
                     (int'(field_dest.band) < NUM_LONG_BANDS);
  assign short_hit = field_done && field_dest.is_short &&
                     (int'(field_dest.band) < NUM_SHORT_BANDS) &&
                     (int'(field_dest.window) < NUM_WINDOWS);

  always_ff @(posedge clk) begin
    if (rst) begin
      scalefac_l <= '0;
    end else begin
      if (start)
        scalefac_l <= '0;
      if (long_hit)
        scalefac_l[field_dest.band] <= field_value;  // wins over the clear in the strobe cycle
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      scalefac_s <= '0;
    end else begin
      if (start)
        scalefac_s <= '0;
      if (short_hit)
        scalefac_s[field_dest.band][field_dest.window] <= field_value;
    end
  end

endmodule

/* rtl/sf_parser.sv */
`timescale 1ns/1ps

module sf_parser #(
  parameter int GR = 0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                si_valid,
  input  sf_pkg::side_info_t  side_info,
  input  logic                bit_valid,
  input  logic                bit_data,
  output sf_pkg::scalefac_l_t scalefac_l,
  output sf_pkg::scalefac_s_t scalefac_s,
  output logic                done
);
  import sf_pkg::*;

  logic        start;
  slen_t       field_width;
  field_dest_t field_dest;
  logic        field_done;
  sf_value_t   field_value;

  // walks the field layout of the granule
  sf_field_seq #(
    .GR (GR)
  ) u_seq (
    .clk         (clk),
    .rst         (rst),
    .si_valid    (si_valid),
    .side_info   (side_info),
    .bit_valid   (bit_valid),
    .field_done  (field_done),
    .start       (start),
    .field_width (field_width),
    .field_dest  (field_dest),
    .done        (done)
  );

  sf_bit_collector u_collect (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .bit_valid   (bit_valid),
    .bit_data    (bit_data),
    .field_width (field_width),
    .field_value (field_value),
    .field_done  (field_done)
  );

  sf_store u_store (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .field_done  (field_done),
    .field_dest  (field_dest),
    .field_value (field_value),
    .scalefac_l  (scalefac_l),
    .scalefac_s  (scalefac_s)
  );

endmodule

/* dv/sf_clk_gen.sv */
`timescale 1ns/1ps

module sf_clk_gen #(
  parameter int HALF_NS = 10  // 20 ns period
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

endmodule

/* dv/sf_parser_chk.sv */
`timescale 1ns/1ps

module sf_parser_chk (
  input logic          clk,
  input logic          rst,
  input logic          done,
  input logic          field_done,
  input sf_pkg::slen_t field_width
);

  // done is a one cycle pulse
  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done stayed high for two cycles in a row");

  a_quiet_after_reset: assert property (@(posedge clk) rst |=> (!done && !field_done))
    else $error("done or field_done active in the cycle after reset");

  a_no_empty_field: assert property (@(posedge clk) disable iff (rst)
      field_done |-> (field_width != '0))
    else $error("field_done fired on a zero width field");

endmodule

bind sf_parser sf_parser_chk chk_inst (
  .clk         (clk),
  .rst         (rst),
  .done        (done),
  .field_done  (field_done),
  .field_width (field_width)
);

/* dv/sf_parser_tb.sv */
`timescale 1ns/1ps

module sf_parser_tb;
  import sf_pkg::*;

  localparam int GR_TB   = 1;
  localparam int TIMEOUT = 2000;  // cycles allowed per granule

  logic        clk;
  logic        rst;
  logic        si_valid;
  side_info_t  side_info;
  logic        bit_valid;
  logic        bit_data;
  scalefac_l_t scalefac_l;
  scalefac_s_t scalefac_s;
  logic        done;

  int unsigned lcg_state = 32'hbad7_f0ac;
  int          errors;
  int          checks;
  int          failed;
  int          test_err0;
  logic        bit_q [$];  // model bit stream, first bit first
  logic [3:0]  exp_l [NUM_LONG_BANDS];
  logic [3:0]  exp_s [NUM_SHORT_BANDS][NUM_WINDOWS];
  int          slen1_tab [16] = '{0, 0, 0, 0, 3, 1, 1, 1, 2, 2, 2, 3, 3, 3, 4, 4};
  int          slen2_tab [16] = '{0, 1, 2, 3, 0, 1, 2, 3, 1, 2, 3, 1, 2, 3, 2, 3};

  sf_clk_gen clk_gen_inst (.clk(clk));

  sf_parser #(.GR(GR_TB)) sf_parser_inst (.*);

  // lcg step, result below n
  function automatic int unsigned rand_range(input int unsigned n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return (lcg_state >> 16) % n;
  endfunction

  function automatic void check_eq(input string what, input int got, input int want);
    checks++;
    assert (got == want) else begin
      $display("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, got, want);
      errors++;
    end
  endfunction

  task automatic check_outputs(input string what, input bit zero_ref);
    for (int b = 0; b < NUM_LONG_BANDS; b++)
      check_eq($sformatf("%s scalefac_l[%0d]", what, b), int'(scalefac_l[b]),
               zero_ref ? 0 : int'(exp_l[b]));
    for (int b = 0; b < NUM_SHORT_BANDS; b++)
      for (int w = 0; w < NUM_WINDOWS; w++)
        check_eq($sformatf("%s scalefac_s[%0d][%0d]", what, b, w), int'(scalefac_s[b][w]),
                 zero_ref ? 0 : int'(exp_s[b][w]));
  endtask

  function automatic side_info_t make_si(input bit short_blk, input logic [3:0] scfsi);
    side_info_t si;
    si.scalefac_compress     = 4'(rand_range(16));
    si.window_switching_flag = short_blk | 1'(rand_range(2));
    // with window switching a long block gets an odd block type
    si.block_type = short_blk ? 2'd2 : (2'(rand_range(4)) | {1'b0, si.window_switching_flag});
    si.scfsi      = scfsi;
    return si;
  endfunction

  // draws each field value and lays its bits out msb first
  function automatic void build_model(input side_info_t si);
    int         w;
    int         r;
    logic [3:0] v;
    logic       short_blk;
    short_blk = si.window_switching_flag && (si.block_type == 2'd2);
    bit_q.delete();
    for (int b = 0; b < NUM_LONG_BANDS; b++) begin
      r = (b < 6) ? 0 : (b < 11) ? 1 : (b < 16) ? 2 : 3;
      w = (r < 2) ? slen1_tab[si.scalefac_compress] : slen2_tab[si.scalefac_compress];
      v = 4'(rand_range(1 << w));
      if (short_blk || (GR_TB == 1 && si.scfsi[r]))
        v = 4'h0;  // region not coded in this granule
      else
        for (int i = w - 1; i >= 0; i--)
          bit_q.push_back(v[i]);
      exp_l[b] = v;
    end
    for (int b = 0; b < NUM_SHORT_BANDS; b++)
      for (int k = 0; k < NUM_WINDOWS; k++) begin
        w = (b < 6) ? slen1_tab[si.scalefac_compress] : slen2_tab[si.scalefac_compress];
        v = short_blk ? 4'(rand_range(1 << w)) : 4'h0;
        if (short_blk)
          for (int i = w - 1; i >= 0; i--)
            bit_q.push_back(v[i]);
        exp_s[b][k] = v;
      end
  endfunction

  // strobe, feed bits with random gaps, wait for done, then compare
  task automatic run_granule(input string what, input side_info_t si, input bit with_strobe,
                             input int gap_pct, input bit check_clear);
    int idx;
    int cycles;
    bit got_done;
    bit last_bit;
    build_model(si);
    cycles    = 0;
    got_done  = 1'b0;
    si_valid  = 1'b1;
    side_info = si;
    bit_valid = with_strobe && (bit_q.size() > 0);  // bit one rides on the strobe
    bit_data  = bit_valid ? bit_q[0] : 1'b0;
    idx       = int'(bit_valid);
    last_bit  = bit_valid;
    while (!got_done && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
      if (check_clear && cycles == 1)
        check_outputs({what, " cleared"}, 1'b1);
      got_done = done;
      if (got_done) begin
        check_eq({what, " bits before done"}, idx, bit_q.size());
        check_eq({what, " done right after last bit"},
                 int'((bit_q.size() == 0) ? (cycles == 1) : last_bit), 1);
      end
      #1;
      si_valid  = 1'b0;
      bit_valid = !got_done && (idx < bit_q.size()) && (rand_range(100) >= gap_pct);
      bit_data  = bit_valid ? bit_q[idx] : 1'(rand_range(2));
      idx      += int'(bit_valid);
      last_bit  = bit_valid;
    end
    if (!got_done) begin
      $display("timeout: %s saw no done within %0d cycles", what, TIMEOUT);
      errors++;
    end
    @(posedge clk);
    #1;
    check_eq({what, " done after its pulse"}, int'(done), 0);
    check_outputs(what, 1'b0);
    #1;
  endtask

  // bits with no granule open must change nothing
  task automatic stray_bits(input string what, input int n, input bit zero_ref);
    for (int i = 0; i < n; i++) begin
      bit_valid = 1'(rand_range(2));
      bit_data  = 1'(rand_range(2));
      @(posedge clk);
      #1;
      check_eq({what, " done"}, int'(done), 0);
      #1;
    end
    bit_valid = 1'b0;
    check_outputs(what, zero_ref);
  endtask

  task automatic end_test(input string name);
    if (errors == test_err0) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  initial begin
    side_info_t si;
    errors    = 0;
    checks    = 0;
    failed    = 0;
    test_err0 = 0;
    rst       = 1'b1;
    si_valid  = 1'b0;
    side_info = '0;
    bit_valid = 1'b0;
    bit_data  = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    @(posedge clk);
    #1;
    check_eq("done after reset", int'(done), 0);
    check_outputs("after reset", 1'b1);
    #1;
    stray_bits("idle after reset", 8, 1'b1);
    end_test("reset");

    for (int i = 0; i < 20; i++)
      run_granule("long", make_si(1'b0, 4'h0), 1'(rand_range(2)), 25, 1'b0);
    end_test("long_blocks");
    for (int i = 0; i < 20; i++)
      run_granule("short", make_si(1'b1, 4'(rand_range(16))), 1'(rand_range(2)), 25, 1'b0);
    end_test("short_blocks");
    for (int i = 0; i < 20; i++)
      run_granule("scfsi", make_si(1'b0, 4'(1 + rand_range(15))), 1'(rand_range(2)), 25, 1'b0);
    end_test("scfsi_reuse");
    for (int i = 0; i < 16; i++)
      run_granule("strobe", make_si(i[0], 4'(rand_range(16))), 1'b1, int'(rand_range(80)), 1'b0);
    end_test("strobe_timing");

    for (int sc = 0; sc < 4; sc++) begin  // slen1 is zero for these
      si = make_si(sc[0], 4'h0);
      si.scalefac_compress = 4'(sc);
      run_granule("slen1 zero", si, 1'b1, 20, 1'b0);
    end
    stray_bits("bits after done", 16, 1'b0);
    si = make_si(1'b0, 4'h0);
    si.scalefac_compress = 4'd15;
    run_granule("before restart", si, 1'b0, 0, 1'b0);
    run_granule("restart", make_si(1'b1, 4'h0), 1'b0, 10, 1'b1);
    end_test("edge_cases");

    $display("tests 6, failed %0d, checks %0d, errors %0d", failed, checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* list.f */
rtl/sf_pkg.sv
rtl/sf_field_seq.sv
rtl/sf_bit_collector.sv
rtl/sf_store.sv
rtl/sf_parser.sv
dv/sf_clk_gen.sv
dv/sf_parser_chk.sv
dv/sf_parser_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = sf_parser_tb
FILELIST  = list.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
